// File: include/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// ==============================
// subcore array
// ==============================
`define SUBCORE_NUM 8
`define SUB_ID_W 4

// ==============================
// instruction fields
// ==============================
`define PC_W 32
`define OP_W 6

// ==============================
// uart timing
// ==============================
// short bit period keeps simulation fast
`define CLKS_PER_BIT 8

`endif

// File: rtl/core_pkg.sv
`include "core_macros.svh"

package core_pkg;

    // ==============================
    // vector types
    // ==============================
    typedef logic [`SUB_ID_W-1:0] sub_id_t;
    typedef logic [`PC_W-1:0]     pc_t;
    typedef logic [7:0]           uart_byte_t;
    // living count shares the index width
    typedef logic [`SUB_ID_W-1:0] sub_count_t;

    // ==============================
    // enums
    // ==============================
    // unlisted opcodes behave as nop
    typedef enum logic [`OP_W-1:0] {
        op_nop   = 6'h00,
        op_fork  = 6'h30,
        op_join  = 6'h31,
        op_inll  = 6'h32,
        op_inlh  = 6'h33,
        op_inul  = 6'h34,
        op_inuh  = 6'h35,
        op_outll = 6'h36
    } opcode_t;

    typedef enum logic [2:0] {
        st_run,
        st_joining,
        st_pre_read,
        st_read,
        st_pre_write,
        st_write
    } ctrl_state_t;

    // ==============================
    // stage requests
    // ==============================
    typedef struct packed {
        opcode_t    op;
        sub_id_t    sub_id;
        uart_byte_t out_byte;
    } decode_req_t;

    typedef struct packed {
        opcode_t op;
        sub_id_t sub_id;
        pc_t     pc;
    } exec_req_t;

endpackage

// File: rtl/uart_rx.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module uart_rx import core_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       ren,
    input  logic       rx,
    output uart_byte_t rdata,
    output logic       rbusy,
    output logic       rdone
);

    localparam int CNT_W = $clog2(`CLKS_PER_BIT);
    localparam int HALF  = `CLKS_PER_BIT / 2;

    logic             rx_meta;
    logic             rx_sync;
    logic             hunting;
    logic [CNT_W-1:0] clk_cnt;
    logic [CNT_W-1:0] cnt_limit;
    logic [3:0]       bit_idx;
    logic             bit_tick;
    uart_byte_t       shreg;

    // two-flop synchronizer on an rx line that idles high
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // half period to mid start bit then a full period per bit
    assign cnt_limit = (bit_idx == 4'd0) ? CNT_W'(HALF - 1) : CNT_W'(`CLKS_PER_BIT - 1);
    assign bit_tick  = rbusy && !hunting && (clk_cnt == cnt_limit);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rbusy   <= 1'b0;
            hunting <= 1'b0;
            rdone   <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else begin
            rdone <= 1'b0;
            if (!rbusy) begin
                if (ren) begin
                    rbusy   <= 1'b1;
                    hunting <= 1'b1;
                end
            end else if (hunting) begin
                if (!rx_sync) begin
                    hunting <= 1'b0;
                    clk_cnt <= '0;
                    bit_idx <= '0;
                end
            end else if (!bit_tick) begin
                clk_cnt <= clk_cnt + CNT_W'(1);
            end else begin
                clk_cnt <= '0;
                if (bit_idx == 4'd0) begin
                    // start bit gone at mid-bit is a glitch
                    if (rx_sync) begin
                        hunting <= 1'b1;
                    end else begin
                        bit_idx <= 4'd1;
                    end
                end else if (bit_idx == 4'd9) begin
                    rbusy   <= 1'b0;
                    rdone   <= 1'b1;
                    bit_idx <= '0;
                end else begin
                    bit_idx <= bit_idx + 4'd1;
                end
            end
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (bit_tick && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
            shreg <= {rx_sync, shreg[7:1]};
        end
        if (bit_tick && bit_idx == 4'd9) begin
            rdata <= shreg;
        end
    end

endmodule

// File: rtl/uart_tx.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module uart_tx import core_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       wen,
    input  uart_byte_t wdata,
    output logic       tx,
    output logic       wbusy,
    output logic       wdone
);

    localparam int CNT_W = $clog2(`CLKS_PER_BIT);

    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_idx;
    logic             bit_end;
    // data bits then stop bit
    logic [8:0]       frame;

    assign bit_end = wbusy && (clk_cnt == CNT_W'(`CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tx      <= 1'b1;
            wbusy   <= 1'b0;
            wdone   <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else begin
            wdone <= 1'b0;
            if (!wbusy) begin
                if (wen) begin
                    wbusy   <= 1'b1;
                    tx      <= 1'b0;
                    clk_cnt <= '0;
                    bit_idx <= '0;
                end
            end else if (!bit_end) begin
                clk_cnt <= clk_cnt + CNT_W'(1);
            end else begin
                clk_cnt <= '0;
                if (bit_idx == 4'd9) begin
                    // stop bit finished
                    wbusy <= 1'b0;
                    wdone <= 1'b1;
                end else begin
                    tx      <= frame[0];
                    bit_idx <= bit_idx + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!wbusy && wen) begin
            frame <= {1'b1, wdata};
        end else if (bit_end && bit_idx != 4'd9) begin
            frame <= {1'b1, frame[8:1]};
        end
    end

    a_tx_idle_high: assert property (@(posedge clk) disable iff (!rstn)
        !wbusy |-> tx);

endmodule

// File: rtl/io_interlock_ctrl.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module io_interlock_ctrl import core_pkg::*; (
    input  logic                    clk,
    input  logic                    rstn,
    input  decode_req_t             decode_req,
    input  logic                    branch_flag,
    input  logic [`SUBCORE_NUM-1:0] subcore_ended,
    input  uart_byte_t              rdata,
    input  logic                    rbusy,
    input  logic                    rdone,
    input  logic                    wbusy,
    input  logic                    wdone,
    output logic                    interlock,
    output logic                    issue,
    output logic                    join_done,
    output logic                    ren,
    output logic                    wen,
    output uart_byte_t              wdata,
    output uart_byte_t              uart_rdata
);

    localparam int SEL_W = $clog2(`SUBCORE_NUM);

    ctrl_state_t state;
    sub_id_t     join_target;
    logic        join_hit;

    // ops only take effect when not stalled and not squashed
    assign issue = !interlock && !branch_flag;

    // out of range target has nothing to wait for
    always_comb begin
        join_hit = 1'b1;
        if (join_target < sub_id_t'(`SUBCORE_NUM)) begin
            join_hit = subcore_ended[join_target[SEL_W-1:0]];
        end
    end

    assign join_done = (state == st_joining) && join_hit;

    // ==============================
    // sequencer
    // ==============================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= st_run;
            interlock  <= 1'b0;
            ren        <= 1'b0;
            wen        <= 1'b0;
            uart_rdata <= '0;
        end else begin
            ren <= 1'b0;
            wen <= 1'b0;
            case (state)
                st_run: begin
                    if (issue) begin
                        case (decode_req.op)
                            op_inll, op_inlh, op_inul, op_inuh: begin
                                state     <= st_pre_read;
                                interlock <= 1'b1;
                            end
                            op_outll: begin
                                state     <= st_pre_write;
                                interlock <= 1'b1;
                            end
                            op_join: begin
                                state     <= st_joining;
                                interlock <= 1'b1;
                            end
                            default: ;
                        endcase
                    end
                end
                st_joining: begin
                    if (join_hit) begin
                        state     <= st_run;
                        interlock <= 1'b0;
                    end
                end
                st_pre_read: begin
                    if (!rbusy) begin
                        ren   <= 1'b1;
                        state <= st_read;
                    end
                end
                st_read: begin
                    if (rdone) begin
                        uart_rdata <= rdata;
                        state      <= st_run;
                        interlock  <= 1'b0;
                    end
                end
                st_pre_write: begin
                    if (!wbusy) begin
                        wen   <= 1'b1;
                        state <= st_write;
                    end
                end
                st_write: begin
                    if (wdone) begin
                        state     <= st_run;
                        interlock <= 1'b0;
                    end
                end
                default: begin
                    state     <= st_run;
                    interlock <= 1'b0;
                end
            endcase
        end
    end

    // operands captured at issue
    always_ff @(posedge clk) begin
        if (state == st_run && issue) begin
            if (decode_req.op == op_outll) begin
                wdata <= decode_req.out_byte;
            end
            if (decode_req.op == op_join) begin
                join_target <= decode_req.sub_id;
            end
        end
    end

    a_ren_not_busy: assert property (@(posedge clk) disable iff (!rstn)
        $rose(ren) |-> !rbusy);

    a_wen_not_busy: assert property (@(posedge clk) disable iff (!rstn)
        $rose(wen) |-> !wbusy);

    a_interlock_state: assert property (@(posedge clk) disable iff (!rstn)
        interlock == (state != st_run));

endmodule

// File: rtl/subcore_tracker.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module subcore_tracker import core_pkg::*; (
    input  logic                    clk,
    input  logic                    rstn,
    input  exec_req_t               exec_req,
    input  logic                    issue,
    input  logic                    join_done,
    output logic [`SUBCORE_NUM-1:0] exec_requested,
    output pc_t                     requested_pc,
    output sub_count_t              living_sub_count
);

    localparam int N = `SUBCORE_NUM;

    logic         fork_go;
    logic [N-1:0] fork_sel;

    assign fork_go = issue && (exec_req.op == op_fork);
    // shift past the top bit leaves no request
    assign fork_sel = {{(N - 1){1'b0}}, 1'b1} << exec_req.sub_id;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            exec_requested   <= '0;
            living_sub_count <= '0;
        end else begin
            exec_requested <= fork_go ? fork_sel : '0;
            // fork and join in one cycle cancel out
            case ({fork_go, join_done})
                2'b10:   living_sub_count <= living_sub_count + sub_count_t'(1);
                2'b01:   living_sub_count <= living_sub_count - sub_count_t'(1);
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fork_go) begin
            requested_pc <= exec_req.pc;
        end
    end

    a_req_onehot: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0(exec_requested));

    a_no_underflow: assert property (@(posedge clk) disable iff (!rstn)
        (join_done && !fork_go) |-> (living_sub_count != '0));

endmodule

// File: rtl/core_control_top.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module core_control_top import core_pkg::*; (
    input  logic                    clk,
    input  logic                    rstn,
    input  decode_req_t             decode_req,
    input  exec_req_t               exec_req,
    input  logic                    branch_flag,
    input  logic [`SUBCORE_NUM-1:0] subcore_ended,
    input  logic                    rx,
    output logic                    interlock,
    output logic [`SUBCORE_NUM-1:0] exec_requested,
    output pc_t                     requested_pc,
    output sub_count_t              living_sub_count,
    output uart_byte_t              uart_rdata,
    output logic                    tx
);

    logic       issue;
    logic       join_done;

    // uart links
    logic       ren;
    uart_byte_t rdata;
    logic       rbusy;
    logic       rdone;
    logic       wen;
    uart_byte_t wdata;
    logic       wbusy;
    logic       wdone;

    io_interlock_ctrl u_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .decode_req    (decode_req),
        .branch_flag   (branch_flag),
        .subcore_ended (subcore_ended),
        .rdata         (rdata),
        .rbusy         (rbusy),
        .rdone         (rdone),
        .wbusy         (wbusy),
        .wdone         (wdone),
        .interlock     (interlock),
        .issue         (issue),
        .join_done     (join_done),
        .ren           (ren),
        .wen           (wen),
        .wdata         (wdata),
        .uart_rdata    (uart_rdata)
    );

    subcore_tracker u_tracker (
        .clk              (clk),
        .rstn             (rstn),
        .exec_req         (exec_req),
        .issue            (issue),
        .join_done        (join_done),
        .exec_requested   (exec_requested),
        .requested_pc     (requested_pc),
        .living_sub_count (living_sub_count)
    );

    uart_rx u_rx (
        .clk   (clk),
        .rstn  (rstn),
        .ren   (ren),
        .rx    (rx),
        .rdata (rdata),
        .rbusy (rbusy),
        .rdone (rdone)
    );

    uart_tx u_tx (
        .clk   (clk),
        .rstn  (rstn),
        .wen   (wen),
        .wdata (wdata),
        .tx    (tx),
        .wbusy (wbusy),
        .wdone (wdone)
    );

endmodule

// File: dv/tb_core_control.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module tb_core_control import core_pkg::*; ();

    localparam int TIMEOUT = 400;
    localparam int BIT     = `CLKS_PER_BIT;

    logic                    clk = 1'b0;
    logic                    rstn;
    decode_req_t             decode_req;
    exec_req_t               exec_req;
    logic                    branch_flag;
    logic [`SUBCORE_NUM-1:0] subcore_ended;
    logic                    rx;
    logic                    interlock;
    logic [`SUBCORE_NUM-1:0] exec_requested;
    pc_t                     requested_pc;
    sub_count_t              living_sub_count;
    uart_byte_t              uart_rdata;
    logic                    tx;

    int     errors = 0;
    integer seed   = 29;

    core_control_top uut (
        .clk              (clk),
        .rstn             (rstn),
        .decode_req       (decode_req),
        .exec_req         (exec_req),
        .branch_flag      (branch_flag),
        .subcore_ended    (subcore_ended),
        .rx               (rx),
        .interlock        (interlock),
        .exec_requested   (exec_requested),
        .requested_pc     (requested_pc),
        .living_sub_count (living_sub_count),
        .uart_rdata       (uart_rdata),
        .tx               (tx)
    );

    always #2 clk = ~clk;

    // ==============================
    // helpers
    // ==============================
    // outputs sampled and inputs driven 1 ns past the edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic wait_interlock(input logic level, input string what);
        int n;
        n = 0;
        while (interlock !== level && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (interlock !== level) begin
            $display("timeout waiting for interlock to %s", what);
            errors++;
        end
    endtask

    // start bit, data lsb first, stop bit
    task automatic send_rx_byte(input uart_byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx = frame[i];
            repeat (BIT) tick();
        end
    endtask

    task automatic capture_tx_byte(output uart_byte_t b);
        int n;
        n = 0;
        b = '0;
        while (tx !== 1'b0 && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (tx !== 1'b0) begin
            $display("timeout waiting for a start bit on tx");
            errors++;
        end else begin
            // to the middle of the start bit
            repeat (BIT / 2) tick();
            for (int i = 0; i < 8; i++) begin
                repeat (BIT) tick();
                b[i] = tx;
            end
            repeat (BIT) tick();
            check_value("tx stop bit", 32'(1'b1), 32'(tx));
        end
    endtask

    // ==============================
    // record handlers
    // ==============================
    task automatic run_fork(input sub_id_t id, input pc_t pc, input sub_count_t exp_cnt,
                            input logic squash);
        logic [`SUBCORE_NUM-1:0] exp_req;
        if (squash) begin
            exp_req = '0;
        end else begin
            exp_req = `SUBCORE_NUM'(1) << id;
        end
        branch_flag     = squash;
        exec_req.op     = op_fork;
        exec_req.sub_id = id;
        exec_req.pc     = pc;
        tick();
        exec_req.op = op_nop;
        branch_flag = 1'b0;
        check_value("exec_requested", 32'(exp_req), 32'(exec_requested));
        if (!squash) begin
            check_value("requested_pc", pc, requested_pc);
        end
        check_value("living_sub_count", 32'(exp_cnt), 32'(living_sub_count));
        check_value("interlock", 32'(1'b0), 32'(interlock));
        // single cycle pulse
        tick();
        check_value("exec_requested", 32'(0), 32'(exec_requested));
    endtask

    task automatic run_output(input uart_byte_t b, input sub_count_t exp_cnt,
                              input logic squash);
        uart_byte_t got;
        int         low_cycles;
        low_cycles          = 0;
        branch_flag         = squash;
        decode_req.op       = op_outll;
        decode_req.out_byte = b;
        tick();
        decode_req.op = op_nop;
        branch_flag   = 1'b0;
        if (squash) begin
            check_value("interlock", 32'(1'b0), 32'(interlock));
            repeat (10 * BIT) begin
                if (tx !== 1'b1) begin
                    low_cycles++;
                end
                tick();
            end
            check_value("tx low cycles", 32'(0), 32'(low_cycles));
        end else begin
            check_value("interlock", 32'(1'b1), 32'(interlock));
            capture_tx_byte(got);
            check_value("tx byte", 32'(b), 32'(got));
            wait_interlock(1'b0, "fall after an output");
        end
        check_value("living_sub_count", 32'(exp_cnt), 32'(living_sub_count));
    endtask

    task automatic run_input(input logic [1:0] sel, input uart_byte_t b,
                             input sub_count_t exp_cnt);
        case (sel)
            2'd0:    decode_req.op = op_inll;
            2'd1:    decode_req.op = op_inlh;
            2'd2:    decode_req.op = op_inul;
            default: decode_req.op = op_inuh;
        endcase
        tick();
        decode_req.op = op_nop;
        check_value("interlock", 32'(1'b1), 32'(interlock));
        send_rx_byte(b);
        wait_interlock(1'b0, "fall after an input");
        check_value("uart_rdata", 32'(b), 32'(uart_rdata));
        check_value("living_sub_count", 32'(exp_cnt), 32'(living_sub_count));
    endtask

    task automatic run_join(input sub_id_t id, input sub_count_t exp_cnt);
        int delay;
        delay             = 1 + (($random(seed) & 32'h7fffffff) % 20);
        decode_req.op     = op_join;
        decode_req.sub_id = id;
        tick();
        decode_req.op = op_nop;
        check_value("interlock", 32'(1'b1), 32'(interlock));
        repeat (delay) begin
            tick();
            check_value("interlock", 32'(1'b1), 32'(interlock));
        end
        subcore_ended = `SUBCORE_NUM'(1) << id;
        wait_interlock(1'b0, "fall after a join");
        check_value("living_sub_count", 32'(exp_cnt), 32'(living_sub_count));
        subcore_ended = '0;
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        int          fd;
        int          r;
        string       line;
        logic [7:0]  kind;
        logic [31:0] idx;
        logic [31:0] val;
        logic [31:0] exp_cnt;

        rstn          = 1'b0;
        decode_req    = '0;
        exec_req      = '0;
        branch_flag   = 1'b0;
        subcore_ended = '0;
        rx            = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;

        check_value("interlock", 32'(1'b0), 32'(interlock));
        check_value("exec_requested", 32'(0), 32'(exec_requested));
        check_value("living_sub_count", 32'(0), 32'(living_sub_count));
        check_value("uart_rdata", 32'(0), 32'(uart_rdata));
        check_value("tx", 32'(1'b1), 32'(tx));
        tick();

        fd = $fopen("dv/core_control_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the input file");
            errors++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                r = $sscanf(line, "%c %h %h %h", kind, idx, val, exp_cnt);
                if (r != 4) begin
                    $display("malformed input line: %s", line);
                    errors++;
                end else begin
                    case (kind)
                        "F": run_fork(sub_id_t'(idx), val, sub_count_t'(exp_cnt), 1'b0);
                        "B": run_fork(sub_id_t'(idx), val, sub_count_t'(exp_cnt), 1'b1);
                        "O": run_output(uart_byte_t'(val), sub_count_t'(exp_cnt), 1'b0);
                        "X": run_output(uart_byte_t'(val), sub_count_t'(exp_cnt), 1'b1);
                        "I": run_input(idx[1:0], uart_byte_t'(val), sub_count_t'(exp_cnt));
                        "J": run_join(sub_id_t'(idx), sub_count_t'(exp_cnt));
                        default: begin
                            $display("unknown record kind in line: %s", line);
                            errors++;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: dv/core_control_input.txt
# kind (F fork, B squashed fork, O output, X squashed output, I input, J join)
# index (hex), pc or byte (hex), expected living count (hex)
F 0 00001000 1
F 3 0000a5a0 2
O 0 5a 2
I 0 c3 2
J 3 0 1
F 7 deadbeef 2
B 5 12345678 2
X 0 ff 2
I 1 0f 2
I 2 81 2
I 3 7e 2
O 0 3c 2
J 0 0 1
F 1 00400000 2
F 2 00800004 3
B 2 0000ffff 3
O 0 a5 3
J 7 0 2
J 2 0 1
J 1 0 0

// File: verilog.f
+incdir+include
rtl/core_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/io_interlock_ctrl.sv
rtl/subcore_tracker.sv
rtl/core_control_top.sv
dv/tb_core_control.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_core_control -f verilog.f

out=$(./obj_dir/Vtb_core_control) || true
echo "$out"

if grep -q "Result: PASSED" <<< "$out"; then
    exit 0
fi
exit 1
